//--- spi_pkg.sv
package spi_pkg;

   // ####################################################################
   // Frame layout
   // ####################################################################

   // Opcode field width, sits at the top of every frame and packet
   localparam int CMD_W = 8;

   // Command opcodes carried in the first frame field
   typedef enum logic [CMD_W-1:0] {
      SPI_WRITE = 8'h01,
      SPI_READ  = 8'h02
   } spi_op_e;

   // ####################################################################
   // Sequencer states
   // ####################################################################

   // Host side
   // Idle waits for a packet, shift runs the sclk bit phases,
   // gap spans the ss trailer, respond holds the read response
   typedef enum logic [1:0] {
      HOST_IDLE  = 2'd0,
      HOST_SHIFT = 2'd1,
      HOST_GAP   = 2'd2,
      HOST_RESP  = 2'd3
   } host_state_e;

   // Target side
   // One state per frame field, plus memory fetch and write commit
   typedef enum logic [2:0] {
      TGT_IDLE   = 3'd0,
      TGT_CMD    = 3'd1,
      TGT_ADDR   = 3'd2,
      TGT_FETCH  = 3'd3,
      TGT_DATA   = 3'd4,
      TGT_COMMIT = 3'd5
   } target_state_e;

endpackage

//--- spi_mem.sv
module spi_mem #(
   parameter int DW        = 32,
   parameter int MEM_DEPTH = 64
) (
   input  logic                         clk,
   input  logic                         mem_en,
   input  logic                         mem_we,
   input  logic [$clog2(MEM_DEPTH)-1:0] mem_addr,
   input  logic [DW-1:0]                mem_wdata,
   output logic [DW-1:0]                mem_rdata
);

   // ####################################################################
   // Storage
   // ####################################################################

   // One word per index
   logic [DW-1:0] mem [MEM_DEPTH];

   // Address is log2 depth wide, so any index is in range
   // Write when enabled with we high
   // Read otherwise, data out the following cycle
   always_ff @(posedge clk) begin
      if (mem_en) begin
         if (mem_we) begin
            mem[mem_addr] <= mem_wdata;
         end else begin
            mem_rdata <= mem[mem_addr];
         end
      end
   end

endmodule

//--- spi_target.sv
module spi_target #(
   parameter int AW        = 16,
   parameter int DW        = 32,
   parameter int MEM_DEPTH = 64
) (
   input  logic                         clk,
   input  logic                         arst_n,
   input  logic                         sclk,
   input  logic                         mosi,
   input  logic                         ss,
   input  logic [DW-1:0]                mem_rdata,
   output logic                         miso,
   output logic                         mem_en,
   output logic                         mem_we,
   output logic [$clog2(MEM_DEPTH)-1:0] mem_addr,
   output logic [DW-1:0]                mem_wdata
);

   localparam int MAW   = $clog2(MEM_DEPTH);
   localparam int FMAX  = (AW > DW) ? AW : DW;
   localparam int CNT_W = $clog2(FMAX + 1);

   spi_pkg::target_state_e state_q;

   logic                      sclk_q;
   logic [CNT_W-1:0]          bit_cnt;
   logic [spi_pkg::CMD_W-1:0] cmd_sr;
   logic [AW-1:0]             addr_sr;
   logic [DW-1:0]             data_sr;
   logic                      fetch_ph;

   logic                      sclk_rise;
   logic                      sclk_fall;
   logic                      is_read;
   logic                      is_write;
   logic                      addr_last;
   logic                      wr_full;
   logic [AW-1:0]             addr_next;

   // ####################################################################
   // Edge detect and field decode
   // ####################################################################

   // sclk delayed one clk
   assign sclk_rise = sclk && !sclk_q;
   assign sclk_fall = !sclk && sclk_q;

   assign is_read  = (cmd_sr == spi_pkg::SPI_READ);
   assign is_write = (cmd_sr == spi_pkg::SPI_WRITE);

   // Address including the bit arriving now
   assign addr_next = {addr_sr[AW-2:0], mosi};
   assign addr_last = (state_q == spi_pkg::TGT_ADDR) && sclk_rise &&
                      (bit_cnt == CNT_W'(AW - 1));

   // Whole data word received
   assign wr_full = (bit_cnt == CNT_W'(DW));

   assign mem_wdata = data_sr;

   // ####################################################################
   // Sequencer
   // ####################################################################

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q  <= spi_pkg::TGT_IDLE;
         sclk_q   <= 1'b0;
         bit_cnt  <= '0;
         cmd_sr   <= '0;
         fetch_ph <= 1'b0;
         miso     <= 1'b1;
         mem_en   <= 1'b0;
         mem_we   <= 1'b0;
      end else begin
         sclk_q <= sclk;
         case (state_q)
            spi_pkg::TGT_IDLE: begin
               miso <= 1'b1;
               if (!ss) begin
                  bit_cnt <= '0;
                  state_q <= spi_pkg::TGT_CMD;
               end
            end
            spi_pkg::TGT_CMD: begin
               // ss high here means abort
               if (ss) begin
                  state_q <= spi_pkg::TGT_IDLE;
               end else if (sclk_rise) begin
                  cmd_sr <= {cmd_sr[spi_pkg::CMD_W-2:0], mosi};
                  if (bit_cnt == CNT_W'(spi_pkg::CMD_W - 1)) begin
                     bit_cnt <= '0;
                     state_q <= spi_pkg::TGT_ADDR;
                  end else begin
                     bit_cnt <= bit_cnt + 1'b1;
                  end
               end
            end
            spi_pkg::TGT_ADDR: begin
               if (ss) begin
                  state_q <= spi_pkg::TGT_IDLE;
               end else if (addr_last) begin
                  bit_cnt <= '0;
                  // Reads start the fetch right away
                  if (is_read) begin
                     mem_en   <= 1'b1;
                     mem_we   <= 1'b0;
                     fetch_ph <= 1'b0;
                     state_q  <= spi_pkg::TGT_FETCH;
                  end else begin
                     state_q <= spi_pkg::TGT_DATA;
                  end
               end else if (sclk_rise) begin
                  bit_cnt <= bit_cnt + 1'b1;
               end
            end
            spi_pkg::TGT_FETCH: begin
               // Enable one cycle, load the word on the next
               mem_en <= 1'b0;
               if (ss) begin
                  state_q <= spi_pkg::TGT_IDLE;
               end else if (!fetch_ph) begin
                  fetch_ph <= 1'b1;
               end else begin
                  fetch_ph <= 1'b0;
                  state_q  <= spi_pkg::TGT_DATA;
               end
            end
            spi_pkg::TGT_DATA: begin
               if (ss) begin
                  // Frame over, commit only a complete write
                  miso <= 1'b1;
                  if (is_write && wr_full) begin
                     mem_en  <= 1'b1;
                     mem_we  <= 1'b1;
                     state_q <= spi_pkg::TGT_COMMIT;
                  end else begin
                     state_q <= spi_pkg::TGT_IDLE;
                  end
               end else begin
                  if (sclk_rise && !wr_full) begin
                     bit_cnt <= bit_cnt + 1'b1;
                  end
                  // Read data MSB first on falling edges
                  if (is_read && sclk_fall) begin
                     miso <= data_sr[DW-1];
                  end
               end
            end
            spi_pkg::TGT_COMMIT: begin
               mem_en  <= 1'b0;
               mem_we  <= 1'b0;
               state_q <= spi_pkg::TGT_IDLE;
            end
            default: state_q <= spi_pkg::TGT_IDLE;
         endcase
      end
   end

   // ####################################################################
   // Shift registers
   // ####################################################################

   always_ff @(posedge clk) begin
      if ((state_q == spi_pkg::TGT_ADDR) && sclk_rise) begin
         addr_sr <= addr_next;
      end
      // Low bits only, memory wraps on its depth
      if (addr_last) begin
         mem_addr <= addr_next[MAW-1:0];
      end
      if ((state_q == spi_pkg::TGT_FETCH) && fetch_ph) begin
         data_sr <= mem_rdata;
      end else if ((state_q == spi_pkg::TGT_DATA) && !ss) begin
         if (is_read && sclk_fall) begin
            data_sr <= {data_sr[DW-2:0], 1'b0};
         end else if (is_write && sclk_rise) begin
            data_sr <= {data_sr[DW-2:0], mosi};
         end
      end
   end

endmodule

//--- spi_host.sv
module spi_host #(
   parameter int AW       = 16,
   parameter int DW       = 32,
   parameter int SCLK_DIV = 4
) (
   input  logic                             clk,
   input  logic                             arst_n,
   input  logic                             access_in,
   input  logic [spi_pkg::CMD_W+AW+DW-1:0]  packet_in,
   input  logic                             wait_in,
   input  logic                             miso,
   output logic                             wait_out,
   output logic                             access_out,
   output logic [spi_pkg::CMD_W+AW+DW-1:0]  packet_out,
   output logic                             sclk,
   output logic                             mosi,
   output logic                             ss
);

   localparam int PW    = spi_pkg::CMD_W + AW + DW;
   localparam int DIV_W = (SCLK_DIV > 1) ? $clog2(SCLK_DIV) : 1;
   localparam int BIT_W = $clog2(PW);

   spi_pkg::host_state_e state_q;

   logic [DIV_W-1:0] div_cnt;
   logic [BIT_W-1:0] bit_cnt;
   logic             is_read;
   logic [PW-1:0]    tx_sr;
   logic [DW-1:0]    rx_sr;
   logic [AW-1:0]    addr_q;

   logic             accept;
   logic             pkt_read;
   logic             div_end;
   logic             rise_evt;
   logic             fall_evt;
   logic             last_bit;
   logic             frame_done;

   // ####################################################################
   // Event decode
   // ####################################################################

   // Intake only while not busy
   assign accept   = access_in && !wait_out && (state_q == spi_pkg::HOST_IDLE);
   assign pkt_read = (packet_in[PW-1 -: spi_pkg::CMD_W] == spi_pkg::SPI_READ);

   // End of one sclk half-period
   assign div_end  = (div_cnt == DIV_W'(SCLK_DIV - 1));

   // sclk about to rise or fall this cycle
   assign rise_evt = (state_q == spi_pkg::HOST_SHIFT) && div_end && !sclk;
   assign fall_evt = (state_q == spi_pkg::HOST_SHIFT) && div_end && sclk;
   assign last_bit = (bit_cnt == BIT_W'(PW - 1));

   // Trailer over with ss already high
   assign frame_done = (state_q == spi_pkg::HOST_GAP) && div_end && ss;

   // MSB of the frame register goes straight out
   assign mosi = tx_sr[PW-1];

   // ####################################################################
   // Sequencer
   // ####################################################################

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q    <= spi_pkg::HOST_IDLE;
         div_cnt    <= '0;
         bit_cnt    <= '0;
         is_read    <= 1'b0;
         sclk       <= 1'b0;
         ss         <= 1'b1;
         wait_out   <= 1'b0;
         access_out <= 1'b0;
      end else begin
         case (state_q)
            spi_pkg::HOST_IDLE: begin
               // Select target and block intake
               if (accept) begin
                  state_q  <= spi_pkg::HOST_SHIFT;
                  div_cnt  <= '0;
                  bit_cnt  <= '0;
                  is_read  <= pkt_read;
                  ss       <= 1'b0;
                  wait_out <= 1'b1;
               end
            end
            spi_pkg::HOST_SHIFT: begin
               if (div_end) begin
                  div_cnt <= '0;
                  if (!sclk) begin
                     sclk <= 1'b1;
                  end else begin
                     // Falling edge closes the bit
                     sclk <= 1'b0;
                     if (last_bit) begin
                        state_q <= spi_pkg::HOST_GAP;
                     end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                     end
                  end
               end else begin
                  div_cnt <= div_cnt + 1'b1;
               end
            end
            spi_pkg::HOST_GAP: begin
               // Half-period low, ss up, half-period high
               if (div_end) begin
                  div_cnt <= '0;
                  if (!ss) begin
                     ss <= 1'b1;
                  end else if (is_read) begin
                     access_out <= 1'b1;
                     state_q    <= spi_pkg::HOST_RESP;
                  end else begin
                     wait_out <= 1'b0;
                     state_q  <= spi_pkg::HOST_IDLE;
                  end
               end else begin
                  div_cnt <= div_cnt + 1'b1;
               end
            end
            spi_pkg::HOST_RESP: begin
               // Response stays put until taken
               if (!wait_in) begin
                  access_out <= 1'b0;
                  wait_out   <= 1'b0;
                  state_q    <= spi_pkg::HOST_IDLE;
               end
            end
            default: state_q <= spi_pkg::HOST_IDLE;
         endcase
      end
   end

   // ####################################################################
   // Frame data path
   // ####################################################################

   always_ff @(posedge clk) begin
      // Reads go out with a zero data field
      if (accept) begin
         addr_q <= packet_in[DW +: AW];
         if (pkt_read) begin
            tx_sr <= {packet_in[PW-1:DW], {DW{1'b0}}};
         end else begin
            tx_sr <= packet_in;
         end
      end else if (fall_evt) begin
         tx_sr <= {tx_sr[PW-2:0], 1'b0};
      end
      // Sample on every rise, last DW bits are the read data
      if (rise_evt) begin
         rx_sr <= {rx_sr[DW-2:0], miso};
      end
      if (frame_done && is_read) begin
         packet_out <= {spi_pkg::SPI_READ, addr_q, rx_sr};
      end
   end

endmodule

//--- spi_loop_top.sv
module spi_loop_top #(
   parameter int AW        = 16,
   parameter int DW        = 32,
   parameter int MEM_DEPTH = 64,
   parameter int SCLK_DIV  = 4
) (
   input  logic                             clk,
   input  logic                             arst_n,
   input  logic                             access_in,
   input  logic [spi_pkg::CMD_W+AW+DW-1:0]  packet_in,
   output logic                             wait_out,
   output logic                             access_out,
   output logic [spi_pkg::CMD_W+AW+DW-1:0]  packet_out,
   input  logic                             wait_in
);

   localparam int MAW = $clog2(MEM_DEPTH);

   // SPI link
   logic           sclk;
   logic           mosi;
   logic           ss;
   logic           miso;

   // Target to memory
   logic           mem_en;
   logic           mem_we;
   logic [MAW-1:0] mem_addr;
   logic [DW-1:0]  mem_wdata;
   logic [DW-1:0]  mem_rdata;

   // ####################################################################
   // Host, emesh packets in and read responses out
   // ####################################################################

   spi_host #(
      .AW       (AW),
      .DW       (DW),
      .SCLK_DIV (SCLK_DIV)
   ) u_host (
      .clk        (clk),
      .arst_n     (arst_n),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_in    (wait_in),
      .miso       (miso),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .sclk       (sclk),
      .mosi       (mosi),
      .ss         (ss)
   );

   // ####################################################################
   // Target and its memory
   // ####################################################################

   spi_target #(
      .AW        (AW),
      .DW        (DW),
      .MEM_DEPTH (MEM_DEPTH)
   ) u_target (
      .clk       (clk),
      .arst_n    (arst_n),
      .sclk      (sclk),
      .mosi      (mosi),
      .ss        (ss),
      .mem_rdata (mem_rdata),
      .miso      (miso),
      .mem_en    (mem_en),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata)
   );

   spi_mem #(
      .DW        (DW),
      .MEM_DEPTH (MEM_DEPTH)
   ) u_mem (
      .clk       (clk),
      .mem_en    (mem_en),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata)
   );

endmodule

//--- tb_spi_loop.sv
module tb_spi_loop;

   timeunit 1ns;
   timeprecision 1ps;

   // ####################################################################
   // Parameters and DUT signals
   // ####################################################################

   // Kept equal to the top level defaults
   localparam int AW        = 16;
   localparam int DW        = 32;
   localparam int MEM_DEPTH = 64;
   localparam int SCLK_DIV  = 4;

   localparam int PW  = spi_pkg::CMD_W + AW + DW;
   localparam int MAW = $clog2(MEM_DEPTH);

   localparam int          CLK_HALF     = 4;
   localparam int          RESET_CYCLES = 16;
   localparam logic [31:0] SEED         = 32'he5880478;

   // Directed block plus random mix
   localparam int NUM_DIRECTED = 6;
   localparam int NUM_RANDOM   = 200;
   localparam int NUM_TXN      = NUM_DIRECTED + NUM_RANDOM;

   // Frame bits plus ss gaps at two half-periods per bit
   localparam int FRAME_CYCLES   = (PW + 4) * 2 * SCLK_DIV;
   localparam int TIMEOUT_CYCLES = NUM_TXN * FRAME_CYCLES * 4 + RESET_CYCLES;

   logic          clk = 1'b0;
   logic          arst_n;
   logic          access_in;
   logic [PW-1:0] packet_in;
   logic          wait_out;
   logic          access_out;
   logic [PW-1:0] packet_out;
   logic          wait_in;

   // Reference model keyed by address modulo depth
   logic [DW-1:0] model [int];
   int            written_q [$];
   logic [PW-1:0] exp_q [$];

   int            reads_issued = 0;
   int            resp_count   = 0;
   int            stall_count  = 0;
   logic          stall_en     = 1'b0;

   // Response held under wait_in at the last negedge
   logic          held_valid = 1'b0;
   logic [PW-1:0] held_pkt;

   spi_loop_top #(
      .AW        (AW),
      .DW        (DW),
      .MEM_DEPTH (MEM_DEPTH),
      .SCLK_DIV  (SCLK_DIV)
   ) u_spi_loop_top (
      .clk        (clk),
      .arst_n     (arst_n),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in)
   );

   // 8 ns clock
   always #CLK_HALF clk = ~clk;

   // ####################################################################
   // Helpers
   // ####################################################################

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic end_with_failure();
      $display("SOME TESTS FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                              input string what);
      if (got !== exp) begin
         $display("FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
         end_with_failure();
      end
   endtask

   // Sends one packet
   // Entered and left 1 ns after a rising edge
   task automatic issue_packet(input logic rd, input logic [AW-1:0] addr,
                               input logic [DW-1:0] wdata, input logic hold);
      logic [PW-1:0] pkt;
      int            idx;
      idx = int'(addr) % MEM_DEPTH;
      // Host busy until wait_out drops
      while (wait_out) begin
         @(posedge clk);
         #1;
      end
      if (rd) begin
         // Data field of a read is ignored by the host
         pkt = {spi_pkg::SPI_READ, addr, wdata};
         exp_q.push_back({spi_pkg::SPI_READ, addr, model[idx]});
         reads_issued++;
      end else begin
         pkt = {spi_pkg::SPI_WRITE, addr, wdata};
         if (!model.exists(idx)) begin
            written_q.push_back(idx);
         end
         model[idx] = wdata;
      end
      access_in = 1'b1;
      packet_in = pkt;
      @(posedge clk);
      #1;
      check_value(64'(wait_out), 64'd1, "wait_out after acceptance");
      // Holding keeps access_in up for the whole busy time
      if (!hold) begin
         access_in = 1'b0;
         packet_in = ~pkt;
      end
      while (wait_out) begin
         if (!rd) begin
            check_value(64'(access_out), 64'd0, "access_out during write");
         end
         @(posedge clk);
         #1;
      end
      access_in = 1'b0;
      check_value(64'(access_out), 64'd0, "access_out after handshake");
      if (rd) begin
         check_value(64'(resp_count), 64'(reads_issued), "responses per accepted read");
      end
   endtask

   // ####################################################################
   // Response monitor sampled at negedge where outputs are stable
   // ####################################################################

   always @(negedge clk) begin
      if (!arst_n) begin
         held_valid <= 1'b0;
      end else begin
         // Stalled response must not move
         if (held_valid) begin
            check_value(64'(access_out), 64'd1, "access_out held under wait_in");
            check_value(64'(packet_out), 64'(held_pkt), "packet_out held under wait_in");
         end
         held_valid <= 1'b0;
         if (access_out) begin
            if (wait_in) begin
               held_valid <= 1'b1;
               held_pkt   <= packet_out;
               stall_count++;
            end else if (resp_count >= exp_q.size()) begin
               $display("Read response at %0t ns with no read outstanding", $time);
               end_with_failure();
            end else begin
               // Taken at the next rising edge
               check_value(64'(packet_out), 64'(exp_q[resp_count]), "read response");
               resp_count++;
            end
         end
      end
   end

   // ####################################################################
   // wait_in stalls from their own generator state
   // ####################################################################

   initial begin : stall_gen
      logic [31:0] srng;
      srng    = xorshift32(~SEED);
      wait_in = 1'b0;
      forever begin
         @(posedge clk);
         #1;
         if (stall_en) begin
            srng    = xorshift32(srng);
            wait_in = (srng[2:0] < 3'd3);
         end else begin
            wait_in = 1'b0;
         end
      end
   end

   // Watchdog
   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("Timeout at %0t ns, the run hung waiting on the DUT", $time);
      end_with_failure();
   end

   // ####################################################################
   // Main sequence
   // ####################################################################

   initial begin
      logic [31:0]   rng;
      logic [AW-1:0] addr;
      logic          do_rd;
      logic          hold;
      int            pick;
      int            alias_n;
      rng       = SEED;
      arst_n    = 1'b0;
      access_in = 1'b0;
      packet_in = '0;

      // Outputs quiet through reset
      repeat (RESET_CYCLES) begin
         @(negedge clk);
         check_value(64'(access_out), 64'd0, "access_out in reset");
         check_value(64'(wait_out), 64'd0, "wait_out in reset");
      end
      @(posedge clk);
      #1;
      arst_n = 1'b1;
      repeat (4) begin
         @(posedge clk);
         #1;
         check_value(64'(access_out), 64'd0, "access_out after reset");
         check_value(64'(wait_out), 64'd0, "wait_out after reset");
      end

      // Directed write and read back with aliasing
      issue_packet(1'b0, 16'h0005, 32'hdeadbeef, 1'b0);
      issue_packet(1'b1, 16'h0005, 32'h0, 1'b0);
      issue_packet(1'b0, 16'h0045, 32'h12345678, 1'b0);
      issue_packet(1'b1, 16'h0005, 32'hffffffff, 1'b1);
      issue_packet(1'b0, 16'h003f, 32'ha5a55a5a, 1'b1);
      issue_packet(1'b1, 16'hffff, 32'h0, 1'b0);

      // Random mix under back-pressure
      stall_en = 1'b1;
      for (int n = 0; n < NUM_RANDOM; n++) begin
         rng   = xorshift32(rng);
         do_rd = (written_q.size() > 0) && rng[0];
         hold  = (rng[5:4] == 2'b00);
         if (do_rd) begin
            pick    = int'(rng[23:8]) % written_q.size();
            rng     = xorshift32(rng);
            // Any upper address bits map to the same memory index
            alias_n = int'(rng[15:0]) % (1 << (AW - MAW));
            addr    = AW'(written_q[pick] + alias_n * MEM_DEPTH);
            rng     = xorshift32(rng);
            issue_packet(1'b1, addr, DW'(rng), hold);
         end else begin
            rng  = xorshift32(rng);
            addr = rng[AW-1:0];
            rng  = xorshift32(rng);
            issue_packet(1'b0, addr, DW'(rng), hold);
         end
      end
      stall_en = 1'b0;
      repeat (8) @(posedge clk);

      check_value(64'(stall_count > 0), 64'd1, "wait_in stalls seen on responses");

      // Verdict
      if ((resp_count == reads_issued) && (exp_q.size() == resp_count)) begin
         $display("ALL TESTS PASSED");
         $finish;
      end else begin
         $display("Response count does not match the number of accepted reads");
         end_with_failure();
      end
   end

endmodule

//--- all.f
spi_pkg.sv
spi_mem.sv
spi_target.sv
spi_host.sv
spi_loop_top.sv
tb_spi_loop.sv

//--- Makefile
# Verilator build and run of the SPI loop-back testbench

VERILATOR  ?= verilator
TOP        ?= tb_spi_loop
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= SOME TESTS FAILED
TIMESCALE  ?= 1ns/1ps
VFLAGS     ?= --binary --timing --timescale $(TIMESCALE) -j 0
LINT_FLAGS ?= --lint-only -Wall --timing --timescale $(TIMESCALE)

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi; \
	if [ $$status -ne 0 ]; then echo "Simulator exited with status $$status"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
